// ==== compile.f ====
+incdir+verilog
verilog/tcp_tx_pkg.sv
verilog/tcp_ka_timer.sv
verilog/tcp_seq_track.sv
verilog/tcp_tx_arb.sv
verilog/tcp_tx_mux.sv
verilog/tcp_tx_top.sv
dv/tb_clk_gen.sv
dv/tcp_tx_tb.sv

// ==== dv/tb_clk_gen.sv ====
/* testbench clock and reset, 10 ns period
   reset held high for RST_CYCLES rising edges */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // released on a rising edge, same as a synchronous source
  initial begin
    rst <= 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== dv/tcp_tx_tb.sv ====
/* testbench for the tcp transmit stage, drives requests, models the port
   and compares every segment at acc with a reference metadata function */
`timescale 1ns/1ps
`include "tcp_tx_consts.svh"

module tcp_tx_tb;

  import tcp_tx_pkg::*;

  localparam int N_TRANS    = 16;
  localparam int RST_CYCLES = 10;
  localparam int MAX_CYCLES = 40 * N_TRANS + `TCP_TX_KA_INTERVAL + RST_CYCLES;

  typedef enum logic [1:0] {k_pld, k_ka, k_ack} kind_t;

  logic          clk;
  logic          rst;
  tcb_t          tcb;
  dev_t          dev;
  tcp_stat_t     status;
  tcp_num_t      loc_ack;
  tcp_opt_sack_t sack;
  logic          send_pld;
  logic          send_ack;
  tcp_pld_info_t pld_info;
  tx_req_t       eng_req;
  tx_rsp_t       eng_rsp;
  tx_req_t       port_req;
  tx_rsp_t       port_rsp;
  logic          pld_sent;
  logic          ack_sent;
  tcp_num_t      last_ack;

  integer        seed = 32'hec1ee058;
  int            cycles = 0;
  // model state, owned by the monitor
  int            done_cnt;
  tcp_num_t      model_seq;
  logic [15:0]   model_id;
  kind_t         cur_kind;
  kind_t         acc_kind;
  logic          exp_pld_p;
  logic          exp_ack_p;
  // expected segment kinds in port order
  kind_t         exp_q[$];
  tcp_pld_info_t exp_pld;

  tb_clk_gen #(.RST_CYCLES(RST_CYCLES)) tb_clk_gen_i (.clk(clk), .rst(rst));

  tcp_tx_top tcp_tx_top_i (
    .clk(clk), .rst(rst), .tcb(tcb), .dev(dev), .status(status), .loc_ack(loc_ack),
    .sack(sack), .send_pld(send_pld), .pld_info(pld_info), .send_ack(send_ack),
    .eng_req(eng_req), .eng_rsp(eng_rsp), .port_req(port_req), .port_rsp(port_rsp),
    .pld_sent(pld_sent), .ack_sent(ack_sent), .last_ack(last_ack)
  );

  function automatic logic [639:0] rand_wide();
    logic [639:0] v;
    for (int i = 0; i < 20; i++) v[i*32 +: 32] = $random(seed);
    return v;
  endfunction

  // expected segment, built from the header rules of the stage
  function automatic tcp_meta_t ref_meta(kind_t kind, tcp_pld_info_t pi, tcp_num_t seq,
                                         logic [15:0] id);
    tcp_meta_t m;
    int        n;
    m = '0;
    m.mac_hdr.dst_mac        = tcb.mac_addr;
    m.mac_hdr.src_mac        = dev.mac_addr;
    m.src_ip                 = dev.ipv4_addr;
    m.dst_ip                 = tcb.ipv4_addr;
    m.mac_known              = 1'b1;
    m.ip_pkt_id              = id;
    m.tcp_hdr.src_port       = tcb.loc_port;
    m.tcp_hdr.dst_port       = tcb.rem_port;
    m.tcp_hdr.tcp_ack_num    = loc_ack;
    m.tcp_hdr.tcp_wnd_size   = `TCP_TX_WINDOW;
    m.tcp_opt_sack           = sack;
    // count leading blocks, the rest of the mask must be clear
    n = 0;
    while (n < 4 && sack.block_pres[3 - n]) n++;
    if (n > 0 && sack.block_pres == ~(4'hf >> n)) begin
      m.tcp_hdr.tcp_offset = `TCP_TX_DEF_OFFSET + 4'(2 * n + 1);
      m.sack_pres          = 1'b1;
    end else begin
      m.tcp_hdr.tcp_offset = `TCP_TX_DEF_OFFSET;
    end
    m.tcp_hdr.tcp_flags   = `TCP_TX_FLAG_ACK;
    m.tcp_hdr.tcp_seq_num = seq;
    if (kind == k_ka) m.tcp_hdr.tcp_seq_num = seq - 32'd1;
    if (kind == k_pld) begin
      m.tcp_hdr.tcp_flags   = `TCP_TX_FLAG_ACK | `TCP_TX_FLAG_PSH;
      m.tcp_hdr.tcp_seq_num = pi.start;
      m.pld_len             = pi.lng;
      m.pld_cks             = pi.cks;
    end
    return m;
  endfunction

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_meta(input string name, input tcp_meta_t got, input tcp_meta_t exp);
    if (got !== exp) fail_stop($sformatf("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_num(input string name, input tcp_num_t got, input tcp_num_t exp);
    if (got !== exp) fail_stop($sformatf("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_pulse(input string name, input logic got, input logic exp);
    if (got !== exp) fail_stop($sformatf("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp));
  endtask

  task automatic check_req(input string name, input tx_req_t got, input tx_req_t exp);
    if (got !== exp) fail_stop($sformatf("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_rsp(input string name, input tx_rsp_t got, input tx_rsp_t exp);
    if (got !== exp) fail_stop($sformatf("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp));
  endtask

  // raise requests, drop each on its sent pulse
  task automatic run_reqs(input logic do_pld, input logic do_ack);
    logic pld_left;
    logic ack_left;
    pld_left = do_pld;
    ack_left = do_ack;
    if (do_pld) exp_q.push_back(k_pld);
    if (do_ack) exp_q.push_back(k_ack);
    if (do_pld) send_pld <= 1'b1;
    if (do_pld) pld_info <= exp_pld;
    if (do_ack) send_ack <= 1'b1;
    while (pld_left || ack_left) begin
      @(posedge clk);
      if (pld_sent) pld_left = 1'b0;
      if (pld_sent) send_pld <= 1'b0;
      if (ack_sent) ack_left = 1'b0;
      if (ack_sent) send_ack <= 1'b0;
      // input moves on once granted, tracker keeps its own copy
      if (port_req.rdy && pld_left) pld_info <= ~exp_pld;
    end
    @(posedge clk);
  endtask

  // one engine exchange while not connected, router checked every cycle
  task automatic run_engine(input tcp_meta_t m);
    logic acc_seen;
    logic finished;
    finished = 1'b0;
    eng_req.meta <= m;
    eng_req.strm <= m.tcp_hdr.tcp_seq_num;
    eng_req.rdy  <= 1'b1;
    while (!finished) begin
      @(negedge clk);
      check_req("port_req", port_req, eng_req);
      check_rsp("eng_rsp", eng_rsp, port_rsp);
      acc_seen = eng_rsp.acc;
      finished = eng_rsp.done;
      @(posedge clk);
      if (acc_seen) eng_req.rdy <= 1'b0;
    end
  endtask

  // port model, acc after 0..5 cycles, done 1..4 cycles later
  initial begin : port_model
    int dly;
    port_rsp <= '0;
    forever begin
      @(posedge clk);
      if (!rst && port_req.rdy) begin
        dly = $unsigned($random(seed)) % 6;
        repeat (dly) @(posedge clk);
        port_rsp.acc <= 1'b1;
        @(posedge clk);
        port_rsp.acc <= 1'b0;
        dly = $unsigned($random(seed)) % 4;
        repeat (dly) @(posedge clk);
        port_rsp.done <= 1'b1;
        @(posedge clk);
        port_rsp.done <= 1'b0;
      end
    end
  end

  // compares at acc, tracks sent pulses, packet id and last sequence
  always @(posedge clk) begin
    if (rst) begin
      model_seq <= `TCP_TX_ISN;
      model_id  <= '0;
      done_cnt  <= 0;
      cur_kind  <= k_ka;
      exp_pld_p <= 1'b0;
      exp_ack_p <= 1'b0;
    end else if (status == tcp_connected) begin
      check_pulse("pld_sent", pld_sent, exp_pld_p);
      check_pulse("ack_sent", ack_sent, exp_ack_p);
      check_rsp("eng_rsp", eng_rsp, '0);
      exp_pld_p <= port_rsp.done && (cur_kind == k_pld);
      exp_ack_p <= port_rsp.done && (cur_kind == k_ack);
      if (port_rsp.acc && exp_q.size() == 0) fail_stop("a segment reached the port unrequested");
      if (port_rsp.acc && exp_q.size() != 0) begin
        acc_kind = exp_q.pop_front();
        check_meta("port_req.meta", port_req.meta,
                   ref_meta(acc_kind, exp_pld, model_seq, model_id));
        cur_kind <= acc_kind;
      end
      if (port_rsp.done) begin
        model_id <= model_id + 16'd1;
        done_cnt <= done_cnt + 1;
        if (cur_kind == k_pld) model_seq <= exp_pld.start + tcp_num_t'(exp_pld.lng);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) fail_stop("timeout, the transmit stage stopped making progress");
  end

  initial begin : stim
    logic [639:0] rnd;
    tcp_meta_t    eng_meta;
    tcp_num_t     new_ack;
    logic [3:0]   masks [6];
    int           tgt;
    masks = '{4'b0000, 4'b1000, 4'b1100, 4'b1110, 4'b1111, 4'b0110};
    // all random stimulus drawn before reset ends
    rnd = rand_wide();
    tcb <= rnd[$bits(tcb_t)-1:0];
    dev <= rnd[639:640-$bits(dev_t)];
    rnd = rand_wide();
    sack <= rnd[$bits(tcp_opt_sack_t)-1:0];
    rnd = rand_wide();
    eng_meta = rnd[$bits(tcp_meta_t)-1:0];
    rnd = rand_wide();
    new_ack = rnd[159:128];
    loc_ack <= rnd[191:160];
    status   <= tcp_connected;
    send_pld <= 1'b0;
    send_ack <= 1'b0;
    pld_info <= '0;
    eng_req  <= '0;
    @(posedge clk);
    while (rst) @(posedge clk);
    // payload, then an ack that reports the advanced sequence
    exp_pld = rnd[63:0];
    run_reqs(1'b1, 1'b0);
    run_reqs(1'b0, 1'b1);
    // both at once, payload first
    exp_pld = rnd[127:64];
    run_reqs(1'b1, 1'b1);
    foreach (masks[i]) begin
      sack.block_pres <= masks[i];
      run_reqs(1'b0, 1'b1);
    end
    // timer restarted on the last ack pulse, one edge ago
    // raise payload and ack in the cycle the probe request comes up
    exp_pld = rnd[255:192];
    repeat (`TCP_TX_KA_INTERVAL - 1) @(posedge clk);
    run_reqs(1'b1, 1'b1);
    // quiet line, timer sends the probe
    exp_q.push_back(k_ka);
    tgt = done_cnt + 1;
    while (done_cnt < tgt) @(posedge clk);
    repeat (2) @(posedge clk);
    loc_ack <= new_ack;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_num("last_ack", last_ack, new_ack);
    @(posedge clk);
    // engine owns the port, arbiter ack waits behind the router
    status <= tcp_closed;
    exp_q.push_back(k_ack);
    send_ack <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_req("port_req", port_req, eng_req);
    end
    @(posedge clk);
    run_engine(eng_meta);
    run_engine(~eng_meta);
    status <= tcp_connected;
    while (!ack_sent) @(posedge clk);
    send_ack <= 1'b0;
    repeat (2) @(posedge clk);
    if (exp_q.size() != 0) begin
      fail_stop("expected segments never reached the port");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tcp transmit stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tcp_tx_tb \
  || { echo "RESULT: build error"; exit 1; }
./obj_dir/Vtcp_tx_tb > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Test passed" sim.log || { echo "RESULT: no verdict in log"; exit 1; }
echo "RESULT: PASS"

// ==== verilog/tcp_ka_timer.sv ====
/* idle timer, raises a keep-alive request after a quiet interval while
   connected and holds it until the probe has been sent */
`timescale 1ns/1ps
`include "tcp_tx_consts.svh"

module tcp_ka_timer #(
  parameter int INTERVAL = `TCP_TX_KA_INTERVAL
) (
  input  logic                 clk,
  input  logic                 rst,
  input  tcp_tx_pkg::tcp_stat_t status,
  input  logic                 pld_sent,
  input  logic                 ack_sent,
  input  logic                 ka_sent,
  output logic                 send_ka
);

  import tcp_tx_pkg::*;

  localparam int CW = $clog2(INTERVAL + 1);

  logic [CW-1:0] idle_cnt;
  logic          restart;

  // any sent segment counts as traffic
  assign restart = pld_sent || ack_sent || ka_sent || (status != tcp_connected);

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      idle_cnt <= '0;
      send_ka  <= 1'b0;
    end else if (idle_cnt == CW'(INTERVAL - 1)) begin
      // counter parks here, request stays up
      send_ka <= 1'b1;
    end else begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

endmodule

// ==== verilog/tcp_seq_track.sv ====
/* last sent sequence number, used by keep-alive and forced ack
   captures payload info on arbitration, advances on pld_sent */
`timescale 1ns/1ps
`include "tcp_tx_consts.svh"

module tcp_seq_track (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pld_start_cap,
  input  logic                     pld_sent,
  input  tcp_tx_pkg::tcp_pld_info_t pld_info,
  output tcp_tx_pkg::tcp_num_t      last_seq
);

  import tcp_tx_pkg::*;

  tcp_pld_info_t pld_cap;

  // copy taken when payload wins, source may move on afterwards
  always_ff @(posedge clk) begin
    if (pld_start_cap) begin
      pld_cap <= pld_info;
    end
  end

  // next unsent byte
  always_ff @(posedge clk) begin
    if (rst) begin
      last_seq <= `TCP_TX_ISN;
    end else if (pld_sent) begin
      last_seq <= pld_cap.start + tcp_num_t'(pld_cap.lng);
    end
  end

endmodule

// ==== verilog/tcp_tx_arb.sv ====
/* transmit arbiter for the connected state, picks payload, keep-alive or
   forced ack, builds the segment metadata and runs one port exchange */
`timescale 1ns/1ps
`include "tcp_tx_consts.svh"

module tcp_tx_arb (
  input  logic                     clk,
  input  logic                     rst,
  input  tcp_tx_pkg::tcb_t          tcb,
  input  tcp_tx_pkg::dev_t          dev,
  input  logic                     send_ka,
  input  logic                     send_pld,
  input  logic                     send_ack,
  input  tcp_tx_pkg::tcp_pld_info_t pld_info,
  input  tcp_tx_pkg::tcp_opt_sack_t sack,
  input  tcp_tx_pkg::tcp_num_t      last_seq,
  input  tcp_tx_pkg::tcp_num_t      loc_ack,
  output tcp_tx_pkg::tx_req_t       arb_req,
  input  tcp_tx_pkg::tx_rsp_t       arb_rsp,
  output logic                     pld_sent,
  output logic                     ka_sent,
  output logic                     ack_sent,
  output logic                     pld_start_cap,
  output tcp_tx_pkg::tcp_num_t      last_ack
);

  import tcp_tx_pkg::*;

  typedef enum logic [1:0] {tx_none, tx_ka, tx_ack, tx_pld} tx_type_t;
  typedef enum logic [1:0] {idle_s, active_s, sent_s} fsm_t;

  fsm_t      fsm;
  tx_type_t  tx_type;
  logic      rdy;
  tcp_meta_t meta;

  // payload wins this edge, tracker grabs pld_info alongside
  assign pld_start_cap = (fsm == idle_s) && send_pld;

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm            <= idle_s;
      tx_type        <= tx_none;
      rdy            <= 1'b0;
      pld_sent       <= 1'b0;
      ka_sent        <= 1'b0;
      ack_sent       <= 1'b0;
      last_ack       <= '0;
      meta.ip_pkt_id <= '0;
    end else begin
      case (fsm)
        idle_s: begin
          // refresh everything not tied to the request kind
          meta.mac_hdr.dst_mac     <= tcb.mac_addr;
          meta.mac_hdr.src_mac     <= dev.mac_addr;
          meta.src_ip              <= dev.ipv4_addr;
          meta.dst_ip              <= tcb.ipv4_addr;
          meta.mac_known           <= 1'b1;
          meta.tcp_hdr.src_port    <= tcb.loc_port;
          meta.tcp_hdr.dst_port    <= tcb.rem_port;
          meta.tcp_hdr.tcp_ack_num <= loc_ack;
          meta.tcp_hdr.tcp_wnd_size <= `TCP_TX_WINDOW;
          meta.tcp_hdr.tcp_cks     <= '0;
          meta.tcp_hdr.tcp_pointer <= '0;
          meta.tcp_opt_sack        <= sack;
          last_ack                 <= loc_ack;
          // option adds 2 words per block plus kind/len padding
          // only contiguous leading blocks are legal
          case (sack.block_pres)
            4'b1000: begin
              meta.tcp_hdr.tcp_offset <= `TCP_TX_DEF_OFFSET + 4'd3;
              meta.sack_pres          <= 1'b1;
            end
            4'b1100: begin
              meta.tcp_hdr.tcp_offset <= `TCP_TX_DEF_OFFSET + 4'd5;
              meta.sack_pres          <= 1'b1;
            end
            4'b1110: begin
              meta.tcp_hdr.tcp_offset <= `TCP_TX_DEF_OFFSET + 4'd7;
              meta.sack_pres          <= 1'b1;
            end
            4'b1111: begin
              meta.tcp_hdr.tcp_offset <= `TCP_TX_DEF_OFFSET + 4'd9;
              meta.sack_pres          <= 1'b1;
            end
            default: begin
              meta.tcp_hdr.tcp_offset <= `TCP_TX_DEF_OFFSET;
              meta.sack_pres          <= 1'b0;
            end
          endcase
          // priority payload, keep-alive, forced ack
          if (send_pld) begin
            tx_type                  <= tx_pld;
            meta.tcp_hdr.tcp_flags   <= `TCP_TX_FLAG_PSH | `TCP_TX_FLAG_ACK;
            meta.tcp_hdr.tcp_seq_num <= pld_info.start;
            meta.pld_len             <= pld_info.lng;
            meta.pld_cks             <= pld_info.cks;
          end else if (send_ka) begin
            // seq one below next byte, peer answers with an ack
            tx_type                  <= tx_ka;
            meta.tcp_hdr.tcp_flags   <= `TCP_TX_FLAG_ACK;
            meta.tcp_hdr.tcp_seq_num <= last_seq - 1'b1;
            meta.pld_len             <= '0;
            meta.pld_cks             <= '0;
          end else if (send_ack) begin
            tx_type                  <= tx_ack;
            meta.tcp_hdr.tcp_flags   <= `TCP_TX_FLAG_ACK;
            meta.tcp_hdr.tcp_seq_num <= last_seq;
            meta.pld_len             <= '0;
            meta.pld_cks             <= '0;
          end
          if (send_pld || send_ka || send_ack) begin
            rdy <= 1'b1;
            fsm <= active_s;
          end
        end
        active_s: begin
          if (arb_rsp.acc) begin
            rdy <= 1'b0;
          end
          if (arb_rsp.done) begin
            pld_sent       <= (tx_type == tx_pld);
            ka_sent        <= (tx_type == tx_ka);
            ack_sent       <= (tx_type == tx_ack);
            tx_type        <= tx_none;
            meta.ip_pkt_id <= meta.ip_pkt_id + 1'b1;
            fsm            <= sent_s;
          end
        end
        sent_s: begin
          // one-cycle pulse, sources drop their request on it
          pld_sent <= 1'b0;
          ka_sent  <= 1'b0;
          ack_sent <= 1'b0;
          fsm      <= idle_s;
        end
        default: fsm <= idle_s;
      endcase
    end
  end

  // no stream data from the arbiter itself
  assign arb_req.rdy  = rdy;
  assign arb_req.meta = meta;
  assign arb_req.strm = '0;

  // each done reports exactly one request kind
  a_one_sent: assert property (@(posedge clk) disable iff (rst)
    $onehot0({pld_sent, ka_sent, ack_sent}));

endmodule

// ==== verilog/tcp_tx_consts.svh ====
/* constants for the tcp transmit arbitration stage
   include in any module that builds headers or times keep-alives */
`ifndef TCP_TX_CONSTS_SVH
`define TCP_TX_CONSTS_SVH

// advertised receive window, fixed for this single connection
`define TCP_TX_WINDOW 16'd1000

// data offset in 32-bit words, no options
`define TCP_TX_DEF_OFFSET 4'd5

// 9-bit flag field, ns down to fin
// ns cwr ece urg ack psh rst syn fin
`define TCP_TX_FLAG_ACK 9'h010
`define TCP_TX_FLAG_PSH 9'h008

// quiet cycles before a keep-alive probe goes out
`define TCP_TX_KA_INTERVAL 64

// initial sequence number
// keep-alive reports isn - 1 before any payload
`define TCP_TX_ISN 32'h1a2b_3c4d

`endif

// ==== verilog/tcp_tx_mux.sv ====
/* output router, gives the transmit port to the arbiter while connected
   and to the connection engine otherwise, checks the port exchange */
`timescale 1ns/1ps

module tcp_tx_mux (
  input  logic                 clk,
  input  logic                 rst,
  input  tcp_tx_pkg::tcp_stat_t status,
  input  tcp_tx_pkg::tx_req_t   arb_req,
  output tcp_tx_pkg::tx_rsp_t   arb_rsp,
  input  tcp_tx_pkg::tx_req_t   eng_req,
  output tcp_tx_pkg::tx_rsp_t   eng_rsp,
  output tcp_tx_pkg::tx_req_t   port_req,
  input  tcp_tx_pkg::tx_rsp_t   port_rsp
);

  import tcp_tx_pkg::*;

  // unselected side sees an idle port
  always_comb begin
    if (status == tcp_connected) begin
      port_req = arb_req;
      arb_rsp  = port_rsp;
      eng_rsp  = '0;
    end else begin
      port_req = eng_req;
      eng_rsp  = port_rsp;
      arb_rsp  = '0;
    end
  end

  // meta held until accepted, unless the owner changed
  a_meta_stable: assert property (@(posedge clk) disable iff (rst)
    (port_req.rdy && !port_rsp.acc) ##1 $stable(status) |-> $stable(port_req.meta));

  // port never accepts an empty request
  a_acc_rdy: assert property (@(posedge clk) disable iff (rst)
    port_rsp.acc |-> port_req.rdy);

endmodule

// ==== verilog/tcp_tx_pkg.sv ====
/* shared types for the tcp transmit stage: headers, metadata, connection
   block and the transmit port request/response pair */
package tcp_tx_pkg;

  typedef logic [31:0] tcp_num_t;

  // connection engine status
  typedef enum logic [2:0] {
    tcp_closed,
    tcp_listening,
    tcp_connecting,
    tcp_connected,
    tcp_disconnecting
  } tcp_stat_t;

  // one connection, remote side
  typedef struct packed {
    logic [15:0] loc_port;
    logic [15:0] rem_port;
    logic [31:0] ipv4_addr;
    logic [47:0] mac_addr;
  } tcb_t;

  // local device addresses
  typedef struct packed {
    logic [31:0] ipv4_addr;
    logic [47:0] mac_addr;
  } dev_t;

  typedef struct packed {
    tcp_num_t    start;
    logic [15:0] lng;
    logic [15:0] cks;
  } tcp_pld_info_t;

  // left/right edge pair
  typedef struct packed {
    tcp_num_t left;
    tcp_num_t right;
  } tcp_sack_blk_t;

  typedef struct packed {
    tcp_sack_blk_t [3:0] sack_blocks;
    logic [3:0]          block_pres;
  } tcp_opt_sack_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    tcp_num_t    tcp_seq_num;
    tcp_num_t    tcp_ack_num;
    logic [3:0]  tcp_offset;
    logic [8:0]  tcp_flags;
    logic [15:0] tcp_wnd_size;
    logic [15:0] tcp_cks;
    logic [15:0] tcp_pointer;
  } tcp_hdr_t;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
  } mac_hdr_t;

  // everything the port needs to frame one segment
  typedef struct packed {
    mac_hdr_t      mac_hdr;
    logic [31:0]   src_ip;
    logic [31:0]   dst_ip;
    tcp_hdr_t      tcp_hdr;
    tcp_opt_sack_t tcp_opt_sack;
    logic          sack_pres;
    logic [15:0]   pld_len;
    logic [15:0]   pld_cks;
    logic [15:0]   ip_pkt_id;
    logic          mac_known;
  } tcp_meta_t;

  // toward the port
  typedef struct packed {
    logic        rdy;
    tcp_meta_t   meta;
    logic [31:0] strm;
  } tx_req_t;

  // back from the port
  typedef struct packed {
    logic acc;
    logic done;
  } tx_rsp_t;

endpackage

// ==== verilog/tcp_tx_top.sv ====
/* transmit arbitration stage for one tcp connection
   timer, sequence tracker, arbiter and port router */
`timescale 1ns/1ps

module tcp_tx_top (
  input  logic                     clk,
  input  logic                     rst,
  input  tcp_tx_pkg::tcb_t          tcb,
  input  tcp_tx_pkg::dev_t          dev,
  input  tcp_tx_pkg::tcp_stat_t     status,
  input  tcp_tx_pkg::tcp_num_t      loc_ack,
  input  tcp_tx_pkg::tcp_opt_sack_t sack,
  input  logic                     send_pld,
  input  tcp_tx_pkg::tcp_pld_info_t pld_info,
  input  logic                     send_ack,
  input  tcp_tx_pkg::tx_req_t       eng_req,
  output tcp_tx_pkg::tx_rsp_t       eng_rsp,
  output tcp_tx_pkg::tx_req_t       port_req,
  input  tcp_tx_pkg::tx_rsp_t       port_rsp,
  output logic                     pld_sent,
  output logic                     ack_sent,
  output tcp_tx_pkg::tcp_num_t      last_ack
);

  import tcp_tx_pkg::*;

  logic     send_ka;
  logic     ka_sent;
  logic     pld_start_cap;
  tcp_num_t last_seq;
  tx_req_t  arb_req;
  tx_rsp_t  arb_rsp;

  tcp_ka_timer tcp_ka_timer_i (
    .clk      (clk),
    .rst      (rst),
    .status   (status),
    .pld_sent (pld_sent),
    .ack_sent (ack_sent),
    .ka_sent  (ka_sent),
    .send_ka  (send_ka)
  );

  tcp_seq_track tcp_seq_track_i (
    .clk           (clk),
    .rst           (rst),
    .pld_start_cap (pld_start_cap),
    .pld_sent      (pld_sent),
    .pld_info      (pld_info),
    .last_seq      (last_seq)
  );

  tcp_tx_arb tcp_tx_arb_i (
    .clk           (clk),
    .rst           (rst),
    .tcb           (tcb),
    .dev           (dev),
    .send_ka       (send_ka),
    .send_pld      (send_pld),
    .send_ack      (send_ack),
    .pld_info      (pld_info),
    .sack          (sack),
    .last_seq      (last_seq),
    .loc_ack       (loc_ack),
    .arb_req       (arb_req),
    .arb_rsp       (arb_rsp),
    .pld_sent      (pld_sent),
    .ka_sent       (ka_sent),
    .ack_sent      (ack_sent),
    .pld_start_cap (pld_start_cap),
    .last_ack      (last_ack)
  );

  tcp_tx_mux tcp_tx_mux_i (
    .clk      (clk),
    .rst      (rst),
    .status   (status),
    .arb_req  (arb_req),
    .arb_rsp  (arb_rsp),
    .eng_req  (eng_req),
    .eng_rsp  (eng_rsp),
    .port_req (port_req),
    .port_rsp (port_rsp)
  );

endmodule
